// File: wbuf_pkg.sv
// package: word, byte-mask, offset and size types, byte count and transfer mask helper
`default_nettype none

package wbuf_pkg;

  ////////////////////////////////////////////////////////////////////
  // word geometry
  ////////////////////////////////////////////////////////////////////

  // bytes per data word
  localparam int unsigned WBUF_BYTES = 8;

  // one data word, byte k sits in lane k
  typedef logic [8*WBUF_BYTES-1:0] word_t;

  // one bit per byte of a word
  typedef logic [WBUF_BYTES-1:0] bmask_t;

  // byte offset inside a word
  typedef logic [$clog2(WBUF_BYTES)-1:0] boff_t;

  // transfer size code
  // 0 byte, 1 halfword, 2 word, 3 dword
  typedef logic [1:0] tsize_t;

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  // byte mask covered by an aligned transfer of the given size at off
  function automatic bmask_t tx_mask(boff_t off, tsize_t size);
    logic [WBUF_BYTES:0] ones;
    // 2**size bytes of ones, then move them up to the offset
    ones = (WBUF_BYTES + 1)'(1) << (4'd1 << size);
    ones = ones - 1'b1;
    return bmask_t'(ones[WBUF_BYTES-1:0] << off);
  endfunction

endpackage

`default_nettype wire

// File: wbuf_rr_arb.sv
// round-robin arbiter whose grant stays locked until the requester takes it
`timescale 1ns/1ns
`default_nettype none

module wbuf_rr_arb #(
  parameter int unsigned  N     = 4,
  localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [N-1:0]     req_i,
  // the current grant is consumed this cycle
  input  logic             take_i,
  output logic [IDX_W-1:0] idx_o,
  output logic             any_o
);

  // last served requester and the held choice
  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [IDX_W-1:0] rr_idx;

  // walk downward so the requester closest after last_q wins
  always_comb begin : p_search
    int cand;
    rr_idx = last_q;
    for (int i = N; i >= 1; i--) begin
      cand = (int'(last_q) + i) % N;
      if (req_i[cand]) begin
        rr_idx = IDX_W'(cand);
      end
    end
  end

  // a locked choice wins over a fresh search
  assign idx_o = lock_q ? lock_idx_q : rr_idx;
  assign any_o = |req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      // start the first search at requester 0
      last_q     <= IDX_W'(N - 1);
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else if (any_o && take_i) begin
      last_q <= idx_o;
      lock_q <= 1'b0;
    end else if (any_o) begin
      // grant not taken, keep it stable
      lock_q     <= 1'b1;
      lock_idx_q <= idx_o;
    end
  end

  // a held grant must still belong to a live requester
  a_idx_live: assert property (@(posedge clk_i) disable iff (!rst_ni) any_o |-> req_i[idx_o])
    else $error("rr_arb: grant %0d points to an idle requester", idx_o);

endmodule

`default_nettype wire

// File: wbuf_write_port.sv
// write port: address match against the entries, free entry search and grant
`timescale 1ns/1ns
`default_nettype none

module wbuf_write_port #(
  parameter int unsigned  DEPTH   = 8,
  parameter int unsigned  WADDR_W = 29,
  localparam int unsigned PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                          req_i,
  input  logic [WADDR_W-1:0]            req_waddr_i,
  input  wbuf_pkg::bmask_t              req_be_i,
  // per-entry valid bytes and word address
  input  wbuf_pkg::bmask_t [DEPTH-1:0]  entry_valid_i,
  input  logic [DEPTH-1:0][WADDR_W-1:0] entry_waddr_i,
  output logic                          gnt_o,
  output logic [PTR_W-1:0]              wr_ptr_o
);

  logic [DEPTH-1:0] hit;
  logic [DEPTH-1:0] free;
  logic [PTR_W-1:0] hit_ptr;
  logic [PTR_W-1:0] free_ptr;

  // an entry is free once all its bytes are gone
  for (genvar k = 0; k < DEPTH; k++) begin : gen_match
    assign free[k] = ~|entry_valid_i[k];
    assign hit[k]  = ~free[k] && (entry_waddr_i[k] == req_waddr_i);
  end

  // lowest index wins for both searches
  always_comb begin : p_ptr
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = DEPTH - 1; k >= 0; k--) begin
      if (hit[k]) begin
        hit_ptr = PTR_W'(k);
      end
      if (free[k]) begin
        free_ptr = PTR_W'(k);
      end
    end
  end

  // merge into the hit entry, else open the free one
  assign wr_ptr_o = (|hit) ? hit_ptr : free_ptr;

  // an empty byte mask stores nothing, so it needs no entry
  assign gnt_o = req_i && ((|hit) || (|free) || !(|req_be_i));

  // a word lives in at most one entry, kept so by the store updates
  always_comb begin : p_chk
    if (req_i) begin
      a_hit_onehot: assert final ($onehot0(hit))
        else $error("write_port: address hits several entries");
    end
  end

endmodule

`default_nettype wire

// File: wbuf_store.sv
// entry array with per-byte valid/dirty/in-flight state, word address and data
`timescale 1ns/1ns
`default_nettype none

module wbuf_store #(
  parameter int unsigned  DEPTH   = 8,
  parameter int unsigned  WADDR_W = 29,
  localparam int unsigned PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // granted core write
  input  logic                          wr_en_i,
  input  logic [PTR_W-1:0]              wr_ptr_i,
  input  logic [WADDR_W-1:0]            req_waddr_i,
  input  wbuf_pkg::bmask_t              req_be_i,
  input  wbuf_pkg::word_t               req_wdata_i,
  // transfer accepted by memory
  input  logic                          send_en_i,
  input  logic [PTR_W-1:0]              send_ptr_i,
  input  wbuf_pkg::bmask_t              send_mask_i,
  // transfer returned by memory
  input  logic                          rel_en_i,
  input  logic [PTR_W-1:0]              rel_ptr_i,
  input  wbuf_pkg::bmask_t              rel_mask_i,
  output wbuf_pkg::bmask_t [DEPTH-1:0]  valid_o,
  output wbuf_pkg::bmask_t [DEPTH-1:0]  dirty_o,
  output wbuf_pkg::bmask_t [DEPTH-1:0]  block_o,
  output logic [DEPTH-1:0][WADDR_W-1:0] waddr_o,
  output wbuf_pkg::word_t [DEPTH-1:0]   data_o,
  output logic                          empty_o
);

  import wbuf_pkg::*;

  // byte state, read as valid/dirty/in-flight
  bmask_t [DEPTH-1:0] valid_d, valid_q;
  bmask_t [DEPTH-1:0] dirty_d, dirty_q;
  bmask_t [DEPTH-1:0] block_d, block_q;

  logic [DEPTH-1:0][WADDR_W-1:0] waddr_q;
  word_t [DEPTH-1:0]             data_q;

  ////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////

  always_comb begin : p_next
    valid_d = valid_q;
    dirty_d = dirty_q;
    block_d = block_q;
    // return: unblock, drop bytes not rewritten while in flight
    if (rel_en_i) begin
      block_d[rel_ptr_i] = block_q[rel_ptr_i] & ~rel_mask_i;
      valid_d[rel_ptr_i] = valid_q[rel_ptr_i] & ~(rel_mask_i & ~dirty_q[rel_ptr_i]);
    end
    // send: bytes leave the dirty set and go in flight
    if (send_en_i) begin
      dirty_d[send_ptr_i] = dirty_d[send_ptr_i] & ~send_mask_i;
      block_d[send_ptr_i] = block_d[send_ptr_i] | send_mask_i;
    end
    // write last, a byte hit while in flight ends up 1/1/1
    if (wr_en_i) begin
      valid_d[wr_ptr_i] = valid_d[wr_ptr_i] | req_be_i;
      dirty_d[wr_ptr_i] = dirty_d[wr_ptr_i] | req_be_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      block_q <= '0;
    end else begin
      valid_q <= valid_d;
      dirty_q <= dirty_d;
      block_q <= block_d;
    end
  end

  // address and data of the masked bytes
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_en_i) begin
      if (|req_be_i) begin
        waddr_q[wr_ptr_i] <= req_waddr_i;
      end
      for (int b = 0; b < WBUF_BYTES; b++) begin
        if (req_be_i[b]) begin
          data_q[wr_ptr_i][8*b +: 8] <= req_wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign valid_o = valid_q;
  assign dirty_o = dirty_q;
  assign block_o = block_q;
  assign waddr_o = waddr_q;
  assign data_o  = data_q;
  assign empty_o = ~|valid_q;

  // 1/0/0 is never reached, a returned clean byte is dropped at once
  for (genvar k = 0; k < DEPTH; k++) begin : gen_chk
    for (genvar b = 0; b < WBUF_BYTES; b++) begin : gen_byte
      a_byte_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        {valid_q[k][b], dirty_q[k][b], block_q[k][b]} inside {3'b000, 3'b110, 3'b101, 3'b111})
        else $error("store: entry %0d byte %0d in illegal state", k, b);
    end
  end

endmodule

`default_nettype wire

// File: wbuf_tx_issue.sv
// transfer issue: dirty entry selection and aligned offset/size/mask forming
`timescale 1ns/1ns
`default_nettype none

module wbuf_tx_issue #(
  parameter int unsigned  DEPTH   = 8,
  parameter int unsigned  WADDR_W = 29,
  localparam int unsigned PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  wbuf_pkg::bmask_t [DEPTH-1:0]  valid_i,
  input  wbuf_pkg::bmask_t [DEPTH-1:0]  dirty_i,
  input  wbuf_pkg::bmask_t [DEPTH-1:0]  block_i,
  input  logic [DEPTH-1:0][WADDR_W-1:0] waddr_i,
  input  wbuf_pkg::word_t [DEPTH-1:0]   data_i,
  input  logic                          slot_free_i,
  input  logic                          mem_ack_i,
  output logic                          mem_req_o,
  // word address followed by the byte offset
  output logic [WADDR_W+2:0]            mem_addr_o,
  output wbuf_pkg::tsize_t              mem_size_o,
  output wbuf_pkg::word_t               mem_wdata_o,
  output logic                          send_en_o,
  output logic [PTR_W-1:0]              send_ptr_o,
  output wbuf_pkg::bmask_t              send_mask_o
);

  import wbuf_pkg::*;

  bmask_t [DEPTH-1:0] sendable;
  logic [DEPTH-1:0]   pending;
  logic               any_pending;
  bmask_t             sel;
  bmask_t             shifted;
  boff_t              off;

  // a word with any byte in flight waits, returns may come out of order
  for (genvar k = 0; k < DEPTH; k++) begin : gen_sendable
    assign sendable[k] = (|block_i[k]) ? '0 : (valid_i[k] & dirty_i[k]);
    assign pending[k]  = |sendable[k];
  end

  // locked, so address, size and data hold while memory stalls
  wbuf_rr_arb #(
    .N      ( DEPTH )
  ) i_entry_arb (
    .clk_i  ( clk_i       ),
    .rst_ni ( rst_ni      ),
    .req_i  ( pending     ),
    .take_i ( send_en_o   ),
    .idx_o  ( send_ptr_o  ),
    .any_o  ( any_pending )
  );

  assign sel = sendable[send_ptr_o];

  // lowest sendable byte
  always_comb begin : p_off
    off = '0;
    for (int b = WBUF_BYTES - 1; b >= 0; b--) begin
      if (sel[b]) begin
        off = boff_t'(b);
      end
    end
  end

  assign shifted = sel >> off;

  // largest aligned size that is fully sendable from off
  always_comb begin : p_size
    if (&sel) begin
      mem_size_o = tsize_t'(3);
    end else if ((off[1:0] == 2'b00) && (&shifted[3:0])) begin
      mem_size_o = tsize_t'(2);
    end else if (!off[0] && (&shifted[1:0])) begin
      mem_size_o = tsize_t'(1);
    end else begin
      mem_size_o = tsize_t'(0);
    end
  end

  assign send_mask_o = tx_mask(off, mem_size_o);
  assign mem_req_o   = any_pending && slot_free_i;
  assign mem_addr_o  = {waddr_i[send_ptr_o], off};
  assign mem_wdata_o = data_i[send_ptr_o];
  assign send_en_o   = mem_req_o && mem_ack_i;

endmodule

`default_nettype wire

// File: wbuf_tx_track.sv
// transfer tracking: slot table, return-ID FIFO and release of returned bytes
`timescale 1ns/1ns
`default_nettype none

module wbuf_tx_track #(
  parameter int unsigned  DEPTH  = 8,
  parameter int unsigned  MAX_TX = 4,
  localparam int unsigned PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int unsigned ID_W   = (MAX_TX > 1) ? $clog2(MAX_TX) : 1,
  localparam int unsigned CNT_W  = $clog2(MAX_TX + 1)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // new transfer accepted by memory
  input  logic             send_en_i,
  input  logic [PTR_W-1:0] send_ptr_i,
  input  wbuf_pkg::bmask_t send_mask_i,
  // return pulse from memory
  input  logic             rtrn_vld_i,
  input  logic [ID_W-1:0]  rtrn_id_i,
  output logic             slot_free_o,
  output logic [ID_W-1:0]  mem_id_o,
  output logic             rel_en_o,
  output logic [PTR_W-1:0] rel_ptr_o,
  output wbuf_pkg::bmask_t rel_mask_o
);

  import wbuf_pkg::*;

  // slot table
  logic [MAX_TX-1:0]            slot_vld_q;
  logic [MAX_TX-1:0][PTR_W-1:0] slot_ptr_q;
  bmask_t [MAX_TX-1:0]          slot_mask_q;

  // return-ID FIFO
  logic [MAX_TX-1:0][ID_W-1:0] fifo_q;
  logic [ID_W-1:0]             rd_q, wr_q;
  logic [CNT_W-1:0]            cnt_q;
  logic [ID_W-1:0]             rel_id;

  function automatic logic [ID_W-1:0] nxt(logic [ID_W-1:0] p);
    return (p == ID_W'(MAX_TX - 1)) ? '0 : p + 1'b1;
  endfunction

  // free slots compete for the next ID
  wbuf_rr_arb #(
    .N      ( MAX_TX )
  ) i_slot_arb (
    .clk_i  ( clk_i       ),
    .rst_ni ( rst_ni      ),
    .req_i  ( ~slot_vld_q ),
    .take_i ( send_en_i   ),
    .idx_o  ( mem_id_o    ),
    .any_o  ( slot_free_o )
  );

  // the FIFO head is popped in the cycle it shows
  assign rel_en_o   = (cnt_q != '0);
  assign rel_id     = fifo_q[rd_q];
  assign rel_ptr_o  = slot_ptr_q[rel_id];
  assign rel_mask_o = slot_mask_q[rel_id];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      slot_vld_q <= '0;
      rd_q       <= '0;
      wr_q       <= '0;
      cnt_q      <= '0;
    end else begin
      if (rel_en_o) begin
        slot_vld_q[rel_id] <= 1'b0;
        rd_q               <= nxt(rd_q);
      end
      if (send_en_i) begin
        slot_vld_q[mem_id_o] <= 1'b1;
      end
      if (rtrn_vld_i) begin
        wr_q <= nxt(wr_q);
      end
      cnt_q <= cnt_q + CNT_W'(rtrn_vld_i) - CNT_W'(rel_en_o);
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (send_en_i) begin
      slot_ptr_q[mem_id_o]  <= send_ptr_i;
      slot_mask_q[mem_id_o] <= send_mask_i;
    end
    if (rtrn_vld_i) begin
      fifo_q[wr_q] <= rtrn_id_i;
    end
  end

  // memory may only return IDs that are outstanding
  a_rel_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rel_en_o |-> slot_vld_q[rel_id])
    else $error("tx_track: release of idle slot %0d", rel_id);

  a_no_alloc_rel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(send_en_i && rel_en_o && (mem_id_o == rel_id)))
    else $error("tx_track: slot %0d allocated and released together", rel_id);

endmodule

`default_nettype wire

// File: wbuf_top.sv
// coalescing store buffer top level: write port, entry store, issue and tracking
`timescale 1ns/1ns
`default_nettype none

module wbuf_top #(
  parameter int unsigned  DEPTH   = 8,
  parameter int unsigned  MAX_TX  = 4,
  parameter int unsigned  WADDR_W = 29,
  localparam int unsigned ID_W    = (MAX_TX > 1) ? $clog2(MAX_TX) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core write port
  input  logic                 req_i,
  input  logic [WADDR_W-1:0]   req_waddr_i,
  input  wbuf_pkg::bmask_t     req_be_i,
  input  wbuf_pkg::word_t      req_wdata_i,
  output logic                 gnt_o,
  output logic                 empty_o,
  // memory port
  input  logic                 mem_ack_i,
  input  logic                 mem_rtrn_vld_i,
  input  logic [ID_W-1:0]      mem_rtrn_id_i,
  output logic                 mem_req_o,
  output logic [WADDR_W+2:0]   mem_addr_o,
  output wbuf_pkg::tsize_t     mem_size_o,
  output wbuf_pkg::word_t      mem_wdata_o,
  output logic [ID_W-1:0]      mem_id_o
);

  import wbuf_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // entry state
  bmask_t [DEPTH-1:0]            valid, dirty, block;
  logic [DEPTH-1:0][WADDR_W-1:0] waddr;
  word_t [DEPTH-1:0]             data;
  logic [PTR_W-1:0]              wr_ptr;

  // send and release strobes
  logic             send_en, rel_en, slot_free;
  logic [PTR_W-1:0] send_ptr, rel_ptr;
  bmask_t           send_mask, rel_mask;

  wbuf_write_port #(.DEPTH(DEPTH), .WADDR_W(WADDR_W)) i_write_port (
    .req_i(req_i), .req_waddr_i(req_waddr_i), .req_be_i(req_be_i),
    .entry_valid_i(valid), .entry_waddr_i(waddr),
    .gnt_o(gnt_o), .wr_ptr_o(wr_ptr)
  );

  wbuf_store #(.DEPTH(DEPTH), .WADDR_W(WADDR_W)) i_store (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .wr_en_i(gnt_o), .wr_ptr_i(wr_ptr), .req_waddr_i(req_waddr_i),
    .req_be_i(req_be_i), .req_wdata_i(req_wdata_i),
    .send_en_i(send_en), .send_ptr_i(send_ptr), .send_mask_i(send_mask),
    .rel_en_i(rel_en), .rel_ptr_i(rel_ptr), .rel_mask_i(rel_mask),
    .valid_o(valid), .dirty_o(dirty), .block_o(block),
    .waddr_o(waddr), .data_o(data), .empty_o(empty_o)
  );

  wbuf_tx_issue #(.DEPTH(DEPTH), .WADDR_W(WADDR_W)) i_tx_issue (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .valid_i(valid), .dirty_i(dirty), .block_i(block),
    .waddr_i(waddr), .data_i(data),
    .slot_free_i(slot_free), .mem_ack_i(mem_ack_i),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
    .mem_size_o(mem_size_o), .mem_wdata_o(mem_wdata_o),
    .send_en_o(send_en), .send_ptr_o(send_ptr), .send_mask_o(send_mask)
  );

  wbuf_tx_track #(.DEPTH(DEPTH), .MAX_TX(MAX_TX)) i_tx_track (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .send_en_i(send_en), .send_ptr_i(send_ptr), .send_mask_i(send_mask),
    .rtrn_vld_i(mem_rtrn_vld_i), .rtrn_id_i(mem_rtrn_id_i),
    .slot_free_o(slot_free), .mem_id_o(mem_id_o),
    .rel_en_o(rel_en), .rel_ptr_o(rel_ptr), .rel_mask_o(rel_mask)
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // free running clock
  initial begin : p_clk
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // reset low for the first cycles, released just after an edge
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_wbuf.sv
// testbench: memory responder, stimulus, reference functions and checks for the store buffer
`timescale 1ns/1ns
`default_nettype none

module tb_wbuf;

  import wbuf_pkg::*;

  localparam int unsigned DEPTH   = 8;
  localparam int unsigned MAX_TX  = 4;
  localparam int unsigned WADDR_W = 29;
  localparam int unsigned ID_W    = $clog2(MAX_TX);
  // 300 random writes drain in well under 40 cycles each, directed tests add little
  localparam int unsigned MAX_CYCLES = 20000;
  // queued returns are released one per cycle, then the state settles
  localparam int unsigned DRAIN_LIMIT = 2 * MAX_TX + 4;

  typedef logic [WADDR_W-1:0] waddr_t;

  logic               clk, rst_n;
  logic               req, gnt, empty;
  waddr_t             req_waddr;
  bmask_t             req_be;
  word_t              req_wdata;
  logic               mem_ack, mem_rtrn_vld, mem_req;
  logic [ID_W-1:0]    mem_rtrn_id, mem_id;
  logic [WADDR_W+2:0] mem_addr;
  tsize_t             mem_size;
  word_t              mem_wdata;

  // shadow of the buffer and the memory, keyed by word address
  bmask_t sh_dirty [waddr_t];
  bmask_t sh_flight [waddr_t];
  word_t  sh_data [waddr_t];
  int     tx_per_word [waddr_t];
  word_t  mem_model [waddr_t];
  bit     seen [waddr_t];
  // outstanding transfers by slot ID
  logic [ID_W-1:0] rtrn_q [$];
  waddr_t          id_waddr [MAX_TX];
  bmask_t          id_mask [MAX_TX];
  bit              id_busy [MAX_TX];
  // granted writes in order, and {offset, size} of each transfer
  waddr_t          g_addr [$];
  bmask_t          g_be [$];
  word_t           g_data [$];
  logic [4:0]      tx_log [$];

  int seed = 48;
  int errors, bad_tests, cycles;
  bit ack_en = 1'b1;
  bit rtrn_en = 1'b1;
  bit stall_q;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(2)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  wbuf_top #(.DEPTH(DEPTH), .MAX_TX(MAX_TX), .WADDR_W(WADDR_W)) DUT (
    .clk_i(clk), .rst_ni(rst_n),
    .req_i(req), .req_waddr_i(req_waddr), .req_be_i(req_be), .req_wdata_i(req_wdata),
    .gnt_o(gnt), .empty_o(empty),
    .mem_ack_i(mem_ack), .mem_rtrn_vld_i(mem_rtrn_vld), .mem_rtrn_id_i(mem_rtrn_id),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_size_o(mem_size),
    .mem_wdata_o(mem_wdata), .mem_id_o(mem_id)
  );

  //////////////////////////////////////////////////////////////////////
  // reference functions
  //////////////////////////////////////////////////////////////////////

  function automatic word_t byte_lanes(bmask_t m);
    word_t w;
    for (int b = 0; b < 8; b++) begin
      w[8*b +: 8] = {8{m[b]}};
    end
    return w;
  endfunction

  // lowest sendable byte, then the largest aligned size fully covered
  function automatic void exp_size(input bmask_t m, output boff_t off, output tsize_t size);
    int lo;
    lo = 0;
    for (int b = 7; b >= 0; b--) begin
      if (m[b]) begin
        lo = b;
      end
    end
    off = boff_t'(lo);
    if (m == 8'hff) begin
      size = 2'd3;
    end else if ((lo % 4 == 0) && (((m >> lo) & 8'h0f) == 8'h0f)) begin
      size = 2'd2;
    end else if ((lo % 2 == 0) && (((m >> lo) & 8'h03) == 8'h03)) begin
      size = 2'd1;
    end else begin
      size = 2'd0;
    end
  endfunction

  // bytes covered by 2**size bytes starting at off
  function automatic bmask_t tx_bytes(boff_t off, tsize_t size);
    bmask_t m;
    m = '0;
    for (int b = 0; b < 8; b++) begin
      if ((b >= int'(off)) && (b < int'(off) + (1 << size))) begin
        m[b] = 1'b1;
      end
    end
    return m;
  endfunction

  // memory word after all granted writes, newest byte wins
  function automatic word_t exp_mem(waddr_t wa);
    word_t w;
    w = '0;
    foreach (g_addr[i]) begin
      if (g_addr[i] == wa) begin
        w = (w & ~byte_lanes(g_be[i])) | (g_data[i] & byte_lanes(g_be[i]));
      end
    end
    return w;
  endfunction

  function automatic word_t mem_word(waddr_t wa);
    return mem_model.exists(wa) ? mem_model[wa] : '0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // monitor and memory responder
  //////////////////////////////////////////////////////////////////////

  task automatic touch(waddr_t wa);
    if (!sh_dirty.exists(wa)) begin
      sh_dirty[wa]    = '0;
      sh_flight[wa]   = '0;
      sh_data[wa]     = '0;
      tx_per_word[wa] = 0;
    end
  endtask

  task automatic check_transfer();
    waddr_t wa;
    boff_t  off;
    tsize_t size;
    bmask_t m;
    word_t  lanes;
    wa = mem_addr[WADDR_W+2:3];
    touch(wa);
    assert (sh_flight[wa] == '0) else begin
      $display("word %h sent again while a transfer to it is in flight", wa);
      errors++;
    end
    assert (sh_dirty[wa] != '0) else begin
      $display("transfer to word %h that holds no dirty bytes", wa);
      errors++;
    end
    exp_size(sh_dirty[wa], off, size);
    assert (mem_addr[2:0] == off) else begin
      $display("mismatch mem_addr_o: got %h expected %h", mem_addr, {wa, off});
      errors++;
    end
    assert (mem_size == size) else begin
      $display("mismatch mem_size_o: got %h expected %h", mem_size, size);
      errors++;
    end
    m = tx_bytes(off, size);
    lanes = byte_lanes(m);
    assert ((mem_wdata & lanes) == (sh_data[wa] & lanes)) else begin
      $display("mismatch mem_wdata_o: got %h expected %h", mem_wdata & lanes,
               sh_data[wa] & lanes);
      errors++;
    end
    assert (!id_busy[mem_id]) else begin
      $display("slot ID %0d handed out while still outstanding", mem_id);
      errors++;
    end
    // memory takes the bytes, the word goes in flight
    mem_model[wa] = (mem_word(wa) & ~lanes) | (mem_wdata & lanes);
    sh_dirty[wa] &= ~m;
    sh_flight[wa] |= m;
    tx_per_word[wa]++;
    id_busy[mem_id]  = 1'b1;
    id_waddr[mem_id] = wa;
    id_mask[mem_id]  = m;
    rtrn_q.push_back(mem_id);
    tx_log.push_back({off, size});
  endtask

  task automatic record_write();
    word_t lanes;
    lanes = byte_lanes(req_be);
    touch(req_waddr);
    sh_dirty[req_waddr] |= req_be;
    sh_data[req_waddr] = (sh_data[req_waddr] & ~lanes) | (req_wdata & lanes);
    g_addr.push_back(req_waddr);
    g_be.push_back(req_be);
    g_data.push_back(req_wdata);
  endtask

  // sampled mid-cycle where all outputs are settled
  always @(negedge clk) begin : p_monitor
    if (rst_n) begin
      assert (!stall_q || mem_req) else begin
        $display("mem_req_o dropped while a transfer waited for its ack");
        errors++;
      end
      // a transfer sees the state before a write of the same cycle
      if (mem_req && mem_ack) begin
        check_transfer();
      end
      if (req && gnt) begin
        record_write();
      end
      stall_q = mem_req && !mem_ack;
    end
  end

  initial begin : p_responder
    int pick;
    mem_ack      = 1'b0;
    mem_rtrn_vld = 1'b0;
    mem_rtrn_id  = '0;
    forever begin
      @(posedge clk);
      #1;
      // ack about one cycle in three
      mem_ack      = ack_en && ($unsigned($random(seed)) % 3 == 0);
      mem_rtrn_vld = 1'b0;
      if (rtrn_en && (rtrn_q.size() > 0) && ($unsigned($random(seed)) % 2 == 0)) begin
        // any outstanding ID may come back first
        pick = int'($unsigned($random(seed)) % rtrn_q.size());
        mem_rtrn_id  = rtrn_q[pick];
        rtrn_q.delete(pick);
        mem_rtrn_vld = 1'b1;
        sh_flight[id_waddr[mem_rtrn_id]] &= ~id_mask[mem_rtrn_id];
        id_busy[mem_rtrn_id] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin : p_watchdog
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the buffer never drained", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // hold the request until granted
  task automatic write_word(waddr_t wa, bmask_t be, word_t wd);
    @(posedge clk);
    #1;
    req       = 1'b1;
    req_waddr = wa;
    req_be    = be;
    req_wdata = wd;
    @(negedge clk);
    while (!gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req = 1'b0;
  endtask

  // one cycle of request, reports whether it was granted
  task automatic try_write(input waddr_t wa, input bmask_t be, input word_t wd,
                           output bit granted);
    @(posedge clk);
    #1;
    req       = 1'b1;
    req_waddr = wa;
    req_be    = be;
    req_wdata = wd;
    @(negedge clk);
    granted = gnt;
    @(posedge clk);
    #1;
    req = 1'b0;
  endtask

  // every written byte sent and every transfer returned, by the shadow
  function automatic bit shadow_idle();
    foreach (sh_dirty[a]) begin
      if (sh_dirty[a] != '0) begin
        return 1'b0;
      end
    end
    return (rtrn_q.size() == 0);
  endfunction

  task automatic wait_drain();
    int n;
    @(negedge clk);
    while (req || !shadow_idle()) begin
      @(negedge clk);
    end
    // the last release still has to reach the entry state
    n = 0;
    while (!empty && (n < DRAIN_LIMIT)) begin
      @(negedge clk);
      n++;
    end
    assert (empty) else begin
      $display("empty_o stayed low after all transfers returned");
      errors++;
    end
  endtask

  task automatic report_test(int n, string name, int start_errors);
    if (errors == start_errors) begin
      $display("test %0d %s: ok", n, name);
    end else begin
      $display("test %0d %s: %0d errors", n, name, errors - start_errors);
      bad_tests++;
    end
  endtask

  task automatic full_word_transfer();
    int e0, t0;
    e0 = errors;
    t0 = tx_log.size();
    write_word(waddr_t'('h40), 8'hff, 64'h0123_4567_89ab_cdef);
    wait_drain();
    assert (tx_log.size() == t0 + 1) else begin
      $display("full word took %0d transfers instead of one", tx_log.size() - t0);
      errors++;
    end
    assert (mem_word(waddr_t'('h40)) == 64'h0123_4567_89ab_cdef) else begin
      $display("mismatch memory word: got %h expected %h", mem_word(waddr_t'('h40)),
               64'h0123_4567_89ab_cdef);
      errors++;
    end
    report_test(1, "full word", e0);
  endtask

  task automatic split_mask_offsets();
    int         e0;
    bmask_t     m;
    boff_t      off;
    tsize_t     size;
    logic [4:0] exp_q [$];
    e0 = errors;
    tx_log.delete();
    write_word(waddr_t'('h48), 8'b0011_1001, 64'h1122_3344_5566_7788);
    wait_drain();
    m = 8'b0011_1001;
    while (m != '0) begin
      exp_size(m, off, size);
      exp_q.push_back({off, size});
      m &= ~tx_bytes(off, size);
    end
    assert (tx_log.size() == exp_q.size()) else begin
      $display("split mask took %0d transfers, expected %0d", tx_log.size(), exp_q.size());
      errors++;
    end
    foreach (exp_q[i]) begin
      if (i < tx_log.size()) begin
        assert (tx_log[i] == exp_q[i]) else begin
          $display("mismatch offset/size %0d: got %h expected %h", i, tx_log[i], exp_q[i]);
          errors++;
        end
      end
    end
    report_test(2, "split mask", e0);
  endtask

  task automatic coalesce_and_fill();
    int e0;
    bit g;
    e0 = errors;
    ack_en = 1'b0;
    try_write(waddr_t'('h100), 8'h0f, 64'haaaa_bbbb_cccc_dddd, g);
    assert (g) else begin
      $display("no grant for the first write to word 100");
      errors++;
    end
    try_write(waddr_t'('h100), 8'hf0, 64'h1111_2222_3333_4444, g);
    assert (g) else begin
      $display("no grant for a merging write to word 100");
      errors++;
    end
    for (int k = 1; k < DEPTH; k++) begin
      try_write(waddr_t'('h100 + k), 8'hff, {8{8'(k)}}, g);
      assert (g) else begin
        $display("no grant for word %h while entries were free", 'h100 + k);
        errors++;
      end
    end
    try_write(waddr_t'('h100 + DEPTH), 8'hff, 64'hdead_beef_dead_beef, g);
    assert (!g) else begin
      $display("full buffer granted a new word");
      errors++;
    end
    // hits still merge into a full buffer
    for (int k = 0; k < DEPTH; k++) begin
      try_write(waddr_t'('h100 + k), 8'h80, {8{8'(k + 'h50)}}, g);
      assert (g) else begin
        $display("hit on buffered word %h got no grant", 'h100 + k);
        errors++;
      end
    end
    @(negedge clk);
    ack_en = 1'b1;
    wait_drain();
    report_test(3, "coalesce and fill", e0);
  endtask

  task automatic overwrite_in_flight();
    int     e0;
    waddr_t wa;
    e0 = errors;
    wa = waddr_t'('h80);
    rtrn_en = 1'b0;
    write_word(wa, 8'hff, 64'h0102_0304_0506_0708);
    while (!(sh_flight.exists(wa) && (sh_flight[wa] != '0))) begin
      @(posedge clk);
    end
    write_word(wa, 8'h0f, 64'hf0f1_f2f3_f4f5_f6f7);
    // return held back while the rewritten bytes wait
    repeat (20) @(negedge clk);
    assert (tx_per_word[wa] == 1) else begin
      $display("word %h sent %0d times before its return", wa, tx_per_word[wa]);
      errors++;
    end
    rtrn_en = 1'b1;
    wait_drain();
    assert (tx_per_word[wa] == 2) else begin
      $display("rewritten word %h went out %0d times, expected 2", wa, tx_per_word[wa]);
      errors++;
    end
    assert (mem_word(wa) == 64'h0102_0304_f4f5_f6f7) else begin
      $display("mismatch memory word: got %h expected %h", mem_word(wa),
               64'h0102_0304_f4f5_f6f7);
      errors++;
    end
    report_test(4, "overwrite in flight", e0);
  endtask

  task automatic random_traffic();
    int     e0;
    waddr_t wa;
    bmask_t be;
    word_t  wd;
    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      // drawn mid-cycle, away from the responder's draws
      @(negedge clk);
      wa = waddr_t'('h200) + waddr_t'($unsigned($random(seed)) % 16);
      be = bmask_t'($random(seed));
      wd = {$random(seed), $random(seed)};
      write_word(wa, be, wd);
    end
    wait_drain();
    // whole image, directed words included
    foreach (g_addr[i]) begin
      seen[g_addr[i]] = 1'b1;
    end
    foreach (seen[a]) begin
      assert (mem_word(a) == exp_mem(a)) else begin
        $display("mismatch memory word %h: got %h expected %h", a, mem_word(a), exp_mem(a));
        errors++;
      end
    end
    report_test(5, "random traffic", e0);
  endtask

  initial begin : p_main
    req       = 1'b0;
    req_waddr = '0;
    req_be    = '0;
    req_wdata = '0;
    @(posedge rst_n);
    full_word_transfer();
    split_mask_offsets();
    coalesce_and_fill();
    overwrite_in_flight();
    random_traffic();
    $display("tests run: 5, tests with errors: %0d, errors: %0d", bad_tests, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
wbuf_pkg.sv
wbuf_rr_arb.sv
wbuf_write_port.sv
wbuf_store.sv
wbuf_tx_issue.sv
wbuf_tx_track.sv
wbuf_top.sv
tb_clk_gen.sv
tb_wbuf.sv

// File: run.sh
#!/bin/sh
# build and run the store buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_wbuf -o tb_wbuf

# the exit status of grep decides pass or fail
./obj_dir/tb_wbuf | tee /dev/stderr | grep -x "Simulation completed successfully" > /dev/null
echo "run.sh: testbench passed"
